// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/10ps -j 0
TOP      := ccc_handler_tb
FILELIST := project.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== project.f ====
verilog/ccc_pkg.sv
verilog/ccc_classify.sv
verilog/ddr_word_counter.sv
verilog/regf_addr_gen.sv
verilog/ccc_sequencer.sv
verilog/ccc_handler.sv
verif/ccc_handler_tb.sv

// ==== verif/ccc_handler_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ticks every third clock, staller answers 2 to 9 cycles late
// concurrent assertions do the checking, first failure stops the run
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ccc_handler_tb;
  import ccc_pkg::*;

  localparam int REGF_BASE = 1000;
  localparam int NUM_VEC   = 8;

  typedef struct packed {
    ccc_desc_t desc;
    logic      direct;  // expected class from the CCC table
    logic      nack;    // target refuses the first data preamble
  } test_vec_t;

  logic        i_sys_clk    = 1'b0;
  logic        i_sys_rst    = 1'b0;
  logic        i_engine_en  = 1'b0;
  ccc_desc_t   i_desc       = '0;
  logic        i_bit_tick   = 1'b0;
  logic        i_rx_sda     = 1'b1;  // open drain idles high
  logic        i_stall_done = 1'b0;
  tx_ctrl_t    o_tx;
  regf_req_t   o_regf;
  logic        o_done;
  err_status_e o_status;
  logic        o_odd;

  test_vec_t   vecs [NUM_VEC];
  test_vec_t   cur        = '0;
  logic [1:0]  tick_div   = 2'd0;
  logic [3:0]  stall_wait = 4'd0;
  logic        started    = 1'b0;
  logic [1:0]  hdr_cnt    = 2'd0;   // restarts seen in this transfer
  logic        data_seen  = 1'b0;   // last byte mode was a payload byte
  logic [6:0]  words_cnt  = 7'd0;   // payload words completed
  logic [6:0]  ones_ticks = 7'd0;
  tx_mode_e    prev_mode  = zero;
  int          done_cnt   = 0;

  logic        exp_def, final_pass, pay_phase, ccc_sec, exp_rd;
  logic [6:0]  exp_hdr, exp_words;
  logic [11:0] pay_start, exp_addr;
  tx_mode_e    exp_pattern;
  logic [3:0]  exp_code;

  ccc_handler #(.REGF_BASE(REGF_BASE)) UUT (.*);

  always #4 i_sys_clk = ~i_sys_clk;

  // SDA bit time is three clocks
  always @(posedge i_sys_clk) begin
    tick_div   <= (tick_div == 2'd2) ? 2'd0 : tick_div + 2'd1;
    i_bit_tick <= (tick_div == 2'd1);
  end

  // SCL staller, one done pulse per pattern
  always @(posedge i_sys_clk) begin
    i_stall_done <= 1'b0;
    if (stall_wait != 4'd0) begin
      stall_wait <= stall_wait - 4'd1;
      if (stall_wait == 4'd1) i_stall_done <= 1'b1;
    end else if (o_tx.stall_en && !i_stall_done) begin
      stall_wait <= 4'(2 + $urandom % 8);
    end
  end

  always @(posedge i_sys_clk) begin
    i_rx_sda <= o_tx.rx_ack_en ? cur.nack : 1'b1;  // low acks
  end

  // follow the transfer from what the serializer is told to send
  always @(posedge i_sys_clk) begin
    prev_mode <= o_tx.tx_mode;
    if (o_done) done_cnt <= done_cnt + 1;
    if (i_engine_en) begin
      started   <= 1'b1;
      hdr_cnt   <= 2'd0;
      data_seen <= 1'b0;
      words_cnt <= 7'd0;
    end else begin
      if (i_stall_done && o_tx.tx_mode == restart_pattern) hdr_cnt <= hdr_cnt + 2'd1;
      if (o_tx.tx_en && o_tx.tx_mode == ser_first_byte) data_seen <= 1'b1;
      else if (o_tx.tx_en && o_tx.tx_mode == ser_byte) data_seen <= 1'b0;
      if (data_seen && prev_mode == ser_sec_byte && o_tx.tx_mode == parity_calc) begin
        words_cnt <= words_cnt + 7'd1;   // first parity bit of a payload word
      end
    end
    if (o_tx.rx_ack_en && i_bit_tick) ones_ticks <= 7'd0;
    else if (i_bit_tick && o_tx.tx_en && o_tx.tx_mode == one) ones_ticks <= ones_ticks + 7'd1;
  end

  always_comb begin
    exp_def    = cur.desc.immediate ? (cur.desc.dtt >= 3'd5) : cur.desc.dbp;
    final_pass = !(cur.direct && hdr_cnt == 2'd0);  // direct sends 0x7E first
    exp_hdr    = (hdr_cnt == 2'd0) ? 7'h7E : DAT_BASE_ADDR + {2'b00, cur.desc.dev_index};
    exp_words  = final_pass ? cur.desc.data_words : 7'd0;
    pay_phase  = o_tx.tx_en && (o_tx.tx_mode == ser_first_byte ||
                                (o_tx.tx_mode == ser_sec_byte && data_seen));
    ccc_sec    = o_tx.tx_en && o_tx.tx_mode == ser_sec_byte && !data_seen;
    exp_rd     = pay_phase || ccc_sec;
    pay_start  = cur.desc.immediate ? 12'(REGF_BASE + 4) + {11'd0, exp_def}
                                    : 12'(REGF_BASE + 8);
    if (pay_phase) begin
      exp_addr = pay_start + {4'd0, words_cnt, 1'b0} + {11'd0, o_tx.tx_mode == ser_sec_byte};
    end else begin
      exp_addr = exp_def ? 12'(REGF_BASE + 2) : 12'(REGF_BASE - 1);
    end
    if (cur.nack || (final_pass && cur.desc.toc)) exp_pattern = exit_pattern;
    else exp_pattern = restart_pattern;
    exp_code = (exp_pattern == exit_pattern) ? stall_exit : stall_restart;
  end

  task automatic flag_mismatch(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("TEST RESULT: FAIL");
    $display("Fail %s got 0x%0h expected 0x%0h at %0t", sig, got, exp, $time);
    $fatal(1);
  endtask

  task automatic stop_with_error(input string what);
    $display("TEST RESULT: FAIL");
    $display("Error: %s at %0t", what, $time);
    $fatal(1);
  endtask

  a_start : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    i_engine_en |=> o_tx.tx_en)
    else flag_mismatch("o_tx.tx_en", 32'($sampled(o_tx.tx_en)), 32'd1);
  a_quiet : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    !started |-> {o_tx.tx_en, o_tx.stall_en, o_tx.rx_ack_en, o_regf.rd_en, o_done, o_odd} == 6'd0)
    else flag_mismatch("control outputs before start", 32'($sampled({o_tx.tx_en,
      o_tx.stall_en, o_tx.rx_ack_en, o_regf.rd_en, o_done, o_odd})), 32'd0);
  a_hdr_addr : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    (o_tx.tx_en && o_tx.tx_mode == ser_address) |-> o_tx.tx_byte[6:0] == exp_hdr)
    else flag_mismatch("o_tx.tx_byte", 32'($sampled(o_tx.tx_byte)), 32'($sampled(exp_hdr)));
  a_ccc_byte : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    (o_tx.tx_en && o_tx.tx_mode == ser_byte) |-> o_tx.tx_byte == cur.desc.cmd)
    else flag_mismatch("o_tx.tx_byte", 32'($sampled(o_tx.tx_byte)), 32'($sampled(cur.desc.cmd)));
  a_rd_en : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_regf.rd_en == exp_rd)
    else flag_mismatch("o_regf.rd_en", 32'($sampled(o_regf.rd_en)), 32'($sampled(exp_rd)));
  a_rd_addr : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_regf.rd_en |-> o_regf.addr == exp_addr)
    else flag_mismatch("o_regf.addr", 32'($sampled(o_regf.addr)), 32'($sampled(exp_addr)));
  a_pattern : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_tx.stall_en |-> o_tx.tx_mode == exp_pattern)
    else flag_mismatch("o_tx.tx_mode", 32'($sampled(o_tx.tx_mode)), 32'($sampled(exp_pattern)));
  a_stall_code : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_tx.stall_en |-> o_tx.tx_byte[3:0] == exp_code)
    else flag_mismatch("o_tx.tx_byte", 32'($sampled(o_tx.tx_byte)), 32'($sampled(exp_code)));
  a_code_valid : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_tx.stall_code_valid == o_tx.stall_en)
    else flag_mismatch("o_tx.stall_code_valid", 32'($sampled(o_tx.stall_code_valid)),
      32'($sampled(o_tx.stall_en)));
  // the ack bit is released to the target
  a_ack_open_drain : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_tx.rx_ack_en |-> !o_tx.sda_pp)
    else flag_mismatch("o_tx.sda_pp", 32'($sampled(o_tx.sda_pp)), 32'd0);
  a_word_count : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    (o_tx.tx_en && o_tx.tx_mode == crc_token) |-> words_cnt == exp_words)
    else flag_mismatch("data words sent", 32'($sampled(words_cnt)), 32'($sampled(exp_words)));
  a_err_ones : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    (cur.nack && o_tx.tx_en && o_tx.tx_mode == exit_pattern && prev_mode != exit_pattern)
      |-> ones_ticks == {1'b0, ERR_ONES_BITS})
    else flag_mismatch("ones ticks", 32'($sampled(ones_ticks)), 32'(ERR_ONES_BITS));
  a_status : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_done |-> o_status == (cur.nack ? nack : success))
    else flag_mismatch("o_status", 32'($sampled(o_status)), 32'($sampled(cur.nack ? nack : success)));
  a_odd : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_done |-> o_odd == cur.desc.data_words[0])
    else flag_mismatch("o_odd", 32'($sampled(o_odd)), 32'($sampled(cur.desc.data_words[0])));

  function automatic test_vec_t make_vec(input logic [7:0] cmd, input logic imm,
      input logic [4:0] dev, input logic toc, input logic dbp, input logic [2:0] dtt,
      input logic [6:0] words, input logic direct, input logic nack_t);
    test_vec_t v;
    v.desc   = '{cmd: cmd, immediate: imm, dev_index: dev, toc: toc, dbp: dbp,
                 dtt: dtt, data_words: words};
    v.direct = direct;
    v.nack   = nack_t;
    return v;
  endfunction

  // ticks per transfer plus slack for the staller and the idle gap
  function automatic int cycle_budget(input test_vec_t v);
    int passes;
    int ticks;
    passes = v.direct ? 2 : 1;
    ticks  = passes * 52 + 20 * int'(v.desc.data_words) + int'(ERR_ONES_BITS) + 20;
    return ticks * 3 + passes * 12 + 10;
  endfunction

  initial begin
    int budget;
    budget = 0;
    wait (i_sys_rst === 1'b1);
    for (int i = 0; i < NUM_VEC; i++) budget += cycle_budget(vecs[i]);
    #(budget * 8);
    stop_with_error("watchdog expired before all descriptors finished");
  end

  initial begin
    void'($urandom(64));
    //                 cmd    imm   dev    toc   dbp   dtt   words  dir   nack
    vecs[0] = make_vec(8'h09, 1'b0, 5'd0,  1'b1, 1'b0, 3'd0, 7'd2, 1'b0, 1'b0);
    vecs[1] = make_vec(8'h01, 1'b0, 5'd0,  1'b0, 1'b1, 3'd0, 7'd1, 1'b0, 1'b0);
    vecs[2] = make_vec(8'h89, 1'b0, 5'd5,  1'b1, 1'b0, 3'd0, 7'd3, 1'b1, 1'b0);
    vecs[3] = make_vec(8'h9A, 1'b1, 5'd3,  1'b0, 1'b0, 3'd5, 7'd1, 1'b1, 1'b0);
    vecs[4] = make_vec(8'h2A, 1'b1, 5'd0,  1'b1, 1'b0, 3'd2, 7'd1, 1'b0, 1'b0);
    vecs[5] = make_vec(8'h00, 1'b0, 5'd0,  1'b0, 1'b0, 3'd0, 7'd1, 1'b0, 1'b1);
    vecs[6] = make_vec(8'h42, 1'b0, 5'd0,  1'b1, 1'b0, 3'd0, 7'd0, 1'b0, 1'b0);
    vecs[7] = make_vec(8'h8A, 1'b0, 5'd31, 1'b1, 1'b1, 3'd0, 7'd2, 1'b1, 1'b0);
    repeat (2) @(posedge i_sys_clk);
    i_sys_rst <= 1'b1;
    repeat (3) @(posedge i_sys_clk);
    for (int i = 0; i < NUM_VEC; i++) begin
      cur         <= vecs[i];
      i_desc      <= vecs[i].desc;   // held until o_done
      i_engine_en <= 1'b1;
      @(posedge i_sys_clk);
      i_engine_en <= 1'b0;
      @(posedge i_sys_clk);
      while (!o_done) @(posedge i_sys_clk);
      repeat (4) @(posedge i_sys_clk);
    end
    if (done_cnt == NUM_VEC) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      stop_with_error("done strobe count differs from descriptor count");
    end
  end

endmodule

// ==== verilog/ccc_classify.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// only the 13 ground level CCCs are known, others decode as broadcast
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ccc_classify (
  input  ccc_pkg::ccc_desc_t i_desc,
  output logic               o_is_direct,
  output logic               o_has_def_byte,
  output logic [6:0]         o_target_addr
);
  import ccc_pkg::*;

  // direct codes have bit 7 set, broadcast table listed for clarity
  always_comb begin
    case (i_desc.cmd)
      8'h80:   o_is_direct = 1'b1;  // ENEC
      8'h81:   o_is_direct = 1'b1;  // DISEC
      8'h89:   o_is_direct = 1'b1;  // SETMWL
      8'h8A:   o_is_direct = 1'b1;  // SETMRL
      8'h8B:   o_is_direct = 1'b1;  // GETMWL
      8'h8C:   o_is_direct = 1'b1;  // GETMRL
      8'h90:   o_is_direct = 1'b1;  // GETSTATUS
      8'h9A:   o_is_direct = 1'b1;  // RSTACT
      8'h00:   o_is_direct = 1'b0;  // ENEC broadcast
      8'h01:   o_is_direct = 1'b0;  // DISEC broadcast
      8'h09:   o_is_direct = 1'b0;  // SETMWL broadcast
      8'h0A:   o_is_direct = 1'b0;  // SETMRL broadcast
      8'h2A:   o_is_direct = 1'b0;  // RSTACT broadcast
      default: o_is_direct = 1'b0;  // unknown goes out as broadcast
    endcase
  end

  // immediate carries it when dtt is 5 to 7
  always_comb begin
    if (i_desc.immediate) begin
      o_has_def_byte = (i_desc.dtt >= 3'd5);
    end else begin
      o_has_def_byte = i_desc.dbp;
    end
  end

  // DAT entries are consecutive from DAT_BASE_ADDR
  assign o_target_addr = DAT_BASE_ADDR + {2'b00, i_desc.dev_index};

endmodule

// ==== verilog/ccc_handler.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// regf data goes straight to the serializer and never passes here
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ccc_handler #(
  parameter int REGF_AW   = ccc_pkg::REGF_ADDR_W,
  parameter int REGF_BASE = 1000
) (
  input  logic                 i_sys_clk,
  input  logic                 i_sys_rst,
  input  logic                 i_engine_en,
  input  ccc_pkg::ccc_desc_t   i_desc,
  input  logic                 i_bit_tick,
  input  logic                 i_rx_sda,
  input  logic                 i_stall_done,
  output ccc_pkg::tx_ctrl_t    o_tx,
  output ccc_pkg::regf_req_t   o_regf,
  output logic                 o_done,
  output ccc_pkg::err_status_e o_status,
  output logic                 o_odd
);
  import ccc_pkg::*;

  logic       is_direct;
  logic       has_def_byte;
  logic [6:0] target_addr;
  logic [5:0] bit_pos;
  logic       word_end;
  logic       last_word;
  logic       word_start;
  logic [5:0] word_len;
  logic       data_load;
  logic       word_done_data;
  logic       ptr_load;
  logic       ptr_step;
  regf_sel_e  sel;

  ccc_classify u_classify (
    .i_desc         (i_desc),
    .o_is_direct    (is_direct),
    .o_has_def_byte (has_def_byte),
    .o_target_addr  (target_addr)
  );

  ddr_word_counter u_word_cnt (
    .i_sys_clk        (i_sys_clk),
    .i_sys_rst        (i_sys_rst),
    .i_bit_tick       (i_bit_tick),
    .i_word_start     (word_start),
    .i_word_len       (word_len),
    .i_data_load      (data_load),
    .i_data_words     (i_desc.data_words),
    .i_word_done_data (word_done_data),
    .o_bit_pos        (bit_pos),
    .o_word_end       (word_end),
    .o_last_word      (last_word)
  );

  regf_addr_gen #(
    .REGF_AW   (REGF_AW),
    .REGF_BASE (REGF_BASE)
  ) u_regf_addr (
    .i_sys_clk      (i_sys_clk),
    .i_sys_rst      (i_sys_rst),
    .i_ptr_load     (ptr_load),
    .i_immediate    (i_desc.immediate),
    .i_has_def_byte (has_def_byte),
    .i_ptr_step     (ptr_step),
    .i_sel          (sel),
    .o_regf         (o_regf)
  );

  ccc_sequencer u_seq (
    .i_sys_clk        (i_sys_clk),
    .i_sys_rst        (i_sys_rst),
    .i_engine_en      (i_engine_en),
    .i_desc           (i_desc),
    .i_is_direct      (is_direct),
    .i_has_def_byte   (has_def_byte),
    .i_target_addr    (target_addr),
    .i_bit_pos        (bit_pos),
    .i_word_end       (word_end),
    .i_last_word      (last_word),
    .i_bit_tick       (i_bit_tick),
    .i_rx_sda         (i_rx_sda),
    .i_stall_done     (i_stall_done),
    .o_tx             (o_tx),
    .o_word_start     (word_start),
    .o_word_len       (word_len),
    .o_data_load      (data_load),
    .o_word_done_data (word_done_data),
    .o_ptr_load       (ptr_load),
    .o_ptr_step       (ptr_step),
    .o_sel            (sel),
    .o_done           (o_done),
    .o_status         (o_status),
    .o_odd            (o_odd)
  );

endmodule

// ==== verilog/ccc_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types for the HDR-DDR CCC write engine, write direction only
// regf request width is REGF_ADDR_W, any REGF_AW override must match it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ccc_pkg;

  typedef enum logic [4:0] {
    idle,
    pre_cmd,      // command word preamble
    cmd_word,     // RnW, code, address, parity
    ack_pre,      // first data preamble with target ack
    ccc_word,     // CCC value plus defining byte or pad
    data_pre,
    data_word,
    crc_word,
    restart_pat,
    exit_pat,
    err_drive,    // ones on SDA before the exit pattern
    finish
  } ccc_state_e;

  // serializer modes, encodings shared with the tx block
  typedef enum logic [3:0] {
    zero             = 4'd0,
    one              = 4'd1,
    special_preamble = 4'd2,  // 01
    seven_zeros      = 4'd3,
    ser_address      = 4'd5,  // 7 bits from tx_byte
    ser_byte         = 4'd6,  // 8 bits from tx_byte
    ser_first_byte   = 4'd7,  // 8 bits from the register file
    ser_sec_byte     = 4'd8,
    parity_calc      = 4'd9,
    crc_token        = 4'd10, // 4'hC
    crc_value        = 4'd11, // 5 bit checksum
    restart_pattern  = 4'd12,
    exit_pattern     = 4'd13
  } tx_mode_e;

  typedef enum logic [3:0] {
    stall_exit    = 4'hE,
    stall_restart = 4'hF
  } stall_code_e;

  typedef enum logic [3:0] {
    success = 4'h0,
    frame   = 4'h3,
    nack    = 4'h5
  } err_status_e;

  typedef enum logic [1:0] {
    sel_none,
    sel_def,
    sel_pad,
    sel_payload
  } regf_sel_e;

  typedef struct packed {
    logic [7:0] cmd;         // CCC value
    logic       immediate;   // attribute bit 0
    logic [4:0] dev_index;
    logic       toc;         // terminate on completion
    logic       dbp;         // regular descriptor carries a defining byte
    logic [2:0] dtt;         // immediate byte count, 5..7 include a defining byte
    logic [6:0] data_words;
  } ccc_desc_t;

  typedef struct packed {
    logic       tx_en;
    tx_mode_e   tx_mode;
    logic [7:0] tx_byte;          // address, CCC value or stall code
    logic       sda_pp;           // 1 push-pull, 0 open drain
    logic       rx_ack_en;
    logic       stall_en;
    logic       stall_code_valid; // tx_byte[3:0] holds a stall_code_e
  } tx_ctrl_t;

  localparam int REGF_ADDR_W = 12;

  typedef struct packed {
    logic                   rd_en;
    logic [REGF_ADDR_W-1:0] addr;
  } regf_req_t;

  localparam logic [5:0] CMD_WORD_BITS  = 6'd20;
  localparam logic [5:0] CRC_WORD_BITS  = 6'd12;
  localparam logic [5:0] ACK_BIT        = 6'd1;   // second preamble bit
  localparam logic [5:0] ERR_ONES_BITS  = 6'd38;
  localparam logic [6:0] BROADCAST_ADDR = 7'h7E;
  localparam logic [6:0] DAT_BASE_ADDR  = 7'd8;   // device index 0
  localparam logic [6:0] IMM_MAX_WORDS  = 7'd2;   // four payload bytes in an immediate

endpackage

// ==== verilog/ccc_sequencer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write CCCs only, i_desc must stay stable until o_done
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ccc_sequencer (
  input  logic                 i_sys_clk,
  input  logic                 i_sys_rst,
  input  logic                 i_engine_en,
  input  ccc_pkg::ccc_desc_t   i_desc,
  input  logic                 i_is_direct,
  input  logic                 i_has_def_byte,
  input  logic [6:0]           i_target_addr,
  input  logic [5:0]           i_bit_pos,
  input  logic                 i_word_end,
  input  logic                 i_last_word,
  input  logic                 i_bit_tick,
  input  logic                 i_rx_sda,
  input  logic                 i_stall_done,
  output ccc_pkg::tx_ctrl_t    o_tx,
  output logic                 o_word_start,
  output logic [5:0]           o_word_len,
  output logic                 o_data_load,
  output logic                 o_word_done_data,
  output logic                 o_ptr_load,
  output logic                 o_ptr_step,
  output ccc_pkg::regf_sel_e   o_sel,
  output logic                 o_done,
  output ccc_pkg::err_status_e o_status,
  output logic                 o_odd
);
  import ccc_pkg::*;

  ccc_state_e  state;
  ccc_state_e  next_state;
  logic        first_pass;   // direct CCC still on its 0x7E header pass
  logic        pre_end;      // second preamble bit done
  logic        imm_overrun;
  logic [6:0]  hdr_addr;
  stall_code_e stall_code;

  assign pre_end     = i_bit_tick && (i_bit_pos == ACK_BIT);
  assign imm_overrun = i_desc.immediate && (i_desc.data_words > IMM_MAX_WORDS);
  assign hdr_addr    = (i_is_direct && !first_pass) ? i_target_addr : BROADCAST_ADDR;
  assign stall_code  = (state == exit_pat) ? stall_exit : stall_restart;

  always_comb begin
    next_state = state;
    case (state)
      idle:      if (i_engine_en) next_state = pre_cmd;
      pre_cmd:   if (pre_end) next_state = cmd_word;
      cmd_word:  if (i_word_end) next_state = ack_pre;
      ack_pre:   if (pre_end) next_state = i_rx_sda ? err_drive : ccc_word;  // high is NACK
      ccc_word: begin
        if (i_word_end) begin
          if (first_pass || i_last_word) next_state = crc_word;  // header pass has no data
          else if (imm_overrun) next_state = err_drive;
          else next_state = data_pre;
        end
      end
      data_pre:  if (pre_end) next_state = data_word;
      data_word: if (i_word_end) next_state = i_last_word ? crc_word : data_pre;
      crc_word: begin
        if (i_word_end) next_state = (first_pass || !i_desc.toc) ? restart_pat : exit_pat;
      end
      restart_pat: if (i_stall_done) next_state = first_pass ? pre_cmd : finish;
      exit_pat:    if (i_stall_done) next_state = finish;
      err_drive:   if (i_word_end) next_state = exit_pat;
      default:     next_state = idle;  // finish lasts one cycle
    endcase
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      state      <= idle;
      first_pass <= 1'b0;
      o_status   <= success;
      o_odd      <= 1'b0;
    end else begin
      state <= next_state;
      if (state == idle && i_engine_en) begin
        first_pass <= i_is_direct;
        o_status   <= success;
        o_odd      <= 1'b0;
      end
      if (state == restart_pat && i_stall_done) first_pass <= 1'b0;
      if (next_state == err_drive && state != err_drive) begin
        o_status <= (state == ack_pre) ? nack : frame;
      end
      if (next_state == finish && state != finish) o_odd <= i_desc.data_words[0];
    end
  end

  // counters restart on every command word and on the error ones
  assign o_data_load      = (next_state == pre_cmd) && (state != pre_cmd);
  assign o_ptr_load       = o_data_load;
  assign o_word_start     = o_data_load || ((next_state == err_drive) && (state != err_drive));
  assign o_word_done_data = (state == data_pre) && pre_end;
  assign o_ptr_step       = (state == data_word) && i_bit_tick &&
                            (i_bit_pos == 6'd9 || i_bit_pos == 6'd17);
  assign o_done           = (state == finish);

  always_comb begin
    case (state)
      crc_word:  o_word_len = CRC_WORD_BITS;
      err_drive: o_word_len = ERR_ONES_BITS;
      default:   o_word_len = CMD_WORD_BITS;
    endcase
  end

  always_comb begin
    o_tx        = '0;
    o_tx.sda_pp = 1'b1;
    o_sel       = sel_none;
    case (state)
      pre_cmd, data_pre: begin
        o_tx.tx_en   = 1'b1;
        o_tx.tx_mode = (state == pre_cmd) ? special_preamble : one;  // 01 or 11
      end
      cmd_word: begin
        o_tx.tx_en   = 1'b1;
        o_tx.tx_byte = {1'b0, hdr_addr};     // kept for the whole word for parity
        if (i_bit_pos >= 6'd18) o_tx.tx_mode = parity_calc;
        else if (i_bit_pos >= 6'd10 && i_bit_pos <= 6'd16) o_tx.tx_mode = ser_address;
        else if (i_bit_pos >= 6'd3 && i_bit_pos <= 6'd9) o_tx.tx_mode = seven_zeros;
        // RnW at bit 2 and the adjust bit 17 stay zero
      end
      ack_pre: begin
        if (i_bit_pos == ACK_BIT) begin
          o_tx.rx_ack_en = 1'b1;             // target pulls low to ack
          o_tx.sda_pp    = 1'b0;
        end else begin
          o_tx.tx_en   = 1'b1;
          o_tx.tx_mode = one;
        end
      end
      ccc_word: begin
        o_tx.tx_en   = 1'b1;
        o_tx.tx_byte = i_desc.cmd;
        if (i_bit_pos >= 6'd18) begin
          o_tx.tx_mode = parity_calc;
        end else if (i_bit_pos >= 6'd10) begin
          o_tx.tx_mode = ser_sec_byte;       // defining byte or zero pad
          o_sel        = i_has_def_byte ? sel_def : sel_pad;
        end else begin
          o_tx.tx_mode = ser_byte;
        end
      end
      data_word: begin
        o_tx.tx_en = 1'b1;
        if (i_bit_pos >= 6'd18) begin
          o_tx.tx_mode = parity_calc;
        end else begin
          o_tx.tx_mode = (i_bit_pos >= 6'd10) ? ser_sec_byte : ser_first_byte;
          o_sel        = sel_payload;
        end
      end
      crc_word: begin
        o_tx.tx_en = 1'b1;
        if (i_bit_pos <= 6'd1) o_tx.tx_mode = special_preamble;
        else if (i_bit_pos <= 6'd5) o_tx.tx_mode = crc_token;
        else if (i_bit_pos <= 6'd10) o_tx.tx_mode = crc_value;
        else o_tx.tx_mode = one;             // trailing bit before the pattern
      end
      restart_pat, exit_pat: begin
        o_tx.tx_en            = 1'b1;
        o_tx.tx_mode          = (state == exit_pat) ? exit_pattern : restart_pattern;
        o_tx.stall_en         = 1'b1;
        o_tx.stall_code_valid = 1'b1;
        o_tx.tx_byte          = {4'h0, stall_code};
      end
      err_drive: begin
        o_tx.tx_en   = 1'b1;
        o_tx.tx_mode = one;
      end
      default: ;
    endcase
  end

  a_done_single : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_done |=> !o_done);

  // staller only runs after a CRC word or the error ones
  a_stall_in_pattern : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_tx.stall_en |-> (state inside {restart_pat, exit_pat}) &&
                      ($past(state) inside {crc_word, err_drive, restart_pat, exit_pat}));

endmodule

// ==== verilog/ddr_word_counter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i_word_len may only change on a word boundary
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ddr_word_counter (
  input  logic       i_sys_clk,
  input  logic       i_sys_rst,
  input  logic       i_bit_tick,
  input  logic       i_word_start,
  input  logic [5:0] i_word_len,
  input  logic       i_data_load,
  input  logic [6:0] i_data_words,
  input  logic       i_word_done_data,
  output logic [5:0] o_bit_pos,
  output logic       o_word_end,
  output logic       o_last_word
);

  logic [6:0] words_left;  // data words not yet started

  // tick on the final bit of the word
  assign o_word_end  = i_bit_tick && (o_bit_pos == i_word_len - 6'd1);
  assign o_last_word = (words_left == 7'd0);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      o_bit_pos <= '0;
    end else if (i_word_start || o_word_end) begin
      o_bit_pos <= '0;                  // wraps straight into the next word
    end else if (i_bit_tick) begin
      o_bit_pos <= o_bit_pos + 6'd1;
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      words_left <= '0;
    end else if (i_data_load) begin
      words_left <= i_data_words;
    end else if (i_word_done_data && !o_last_word) begin
      words_left <= words_left - 7'd1;  // counted once its preamble is out
    end
  end

  a_bit_pos_in_word : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_bit_pos < i_word_len);

  // the sequencer never starts a data word the descriptor did not ask for
  a_no_extra_word : assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    i_word_done_data |-> !o_last_word);

endmodule

// ==== verilog/regf_addr_gen.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte wide register file, descriptor area at REGF_BASE
// pad byte of zeros must sit at REGF_BASE-1
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module regf_addr_gen #(
  parameter int REGF_AW   = ccc_pkg::REGF_ADDR_W,
  parameter int REGF_BASE = 1000
) (
  input  logic               i_sys_clk,
  input  logic               i_sys_rst,
  input  logic               i_ptr_load,
  input  logic               i_immediate,
  input  logic               i_has_def_byte,
  input  logic               i_ptr_step,
  input  ccc_pkg::regf_sel_e i_sel,
  output ccc_pkg::regf_req_t o_regf
);
  import ccc_pkg::*;

  localparam logic [REGF_AW-1:0] DEF_ADDR  = REGF_AW'(REGF_BASE + 2);
  localparam logic [REGF_AW-1:0] PAD_ADDR  = REGF_AW'(REGF_BASE - 1);
  localparam logic [REGF_AW-1:0] REG_START = REGF_AW'(REGF_BASE + 8);
  localparam logic [REGF_AW-1:0] IMM_START = REGF_AW'(REGF_BASE + 4);

  logic [REGF_AW-1:0] payload_ptr;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      payload_ptr <= '0;
    end else if (i_ptr_load) begin
      if (i_immediate) begin
        // defining byte takes the first immediate slot
        payload_ptr <= IMM_START + {{(REGF_AW-1){1'b0}}, i_has_def_byte};
      end else begin
        payload_ptr <= REG_START;
      end
    end else if (i_ptr_step) begin
      payload_ptr <= payload_ptr + REGF_AW'(1);  // one per byte sent
    end
  end

  always_comb begin
    o_regf.rd_en = (i_sel != sel_none);
    case (i_sel)
      sel_def:     o_regf.addr = DEF_ADDR;
      sel_pad:     o_regf.addr = PAD_ADDR;
      sel_payload: o_regf.addr = payload_ptr;
      default:     o_regf.addr = '0;
    endcase
  end

endmodule
